//--- hw/pet_mem_pkg.sv
// Shared widths, requester indices and screen geometry for the PET memory system
// VIDEO_GAP must be at least 1, and the screen must fit below the top of SRAM

package pet_mem_pkg;

    // ******************************************************************
    // Memory widths
    // ******************************************************************
    localparam int RAM_ADDR_WIDTH = 15;     // 32 KB of SRAM
    localparam int DATA_WIDTH     = 8;

    // ******************************************************************
    // Arbiter requesters
    // ******************************************************************
    localparam int NUM_REQ   = 3;
    localparam int REQ_VIDEO = 0;           // Fixed priority
    localparam int REQ_CPU   = 1;
    localparam int REQ_HOST  = 2;

    // ******************************************************************
    // Video screen buffer
    // ******************************************************************

    // First byte of the 40 x 25 character screen
    localparam logic [RAM_ADDR_WIDTH-1:0] VIDEO_BASE = 15'h0000;

    localparam int VIDEO_BYTES = 1000;

    // Idle cycles after each fetch, left over for the APB ports
    localparam int VIDEO_GAP = 3;

    // Counter widths derived from the geometry
    localparam int VIDEO_OFFSET_WIDTH = $clog2(VIDEO_BYTES);
    localparam int VIDEO_GAP_WIDTH    = $clog2(VIDEO_GAP + 1);

endpackage

//--- hw/apb_mem_port.sv
// APB completer turning each transfer into one arbitrated SRAM access
// The master must hold psel, penable, paddr, pwrite and pwdata until pready
// No error response, so PSLVERR is left out

`timescale 1ns/1ps

module apb_mem_port (
    input  logic                                  clock_i,
    input  logic                                  reset_i,

    // APB completer side
    input  logic                                  psel_i,
    input  logic                                  penable_i,
    input  logic                                  pwrite_i,
    input  logic [pet_mem_pkg::RAM_ADDR_WIDTH-1:0] paddr_i,
    input  logic [pet_mem_pkg::DATA_WIDTH-1:0]     pwdata_i,
    output logic [pet_mem_pkg::DATA_WIDTH-1:0]     prdata_o,
    output logic                                  pready_o,

    // Request to the arbiter
    output logic                                  req_o,
    output logic                                  req_write_o,
    output logic [pet_mem_pkg::RAM_ADDR_WIDTH-1:0] req_addr_o,
    output logic [pet_mem_pkg::DATA_WIDTH-1:0]     req_wdata_o,
    input  logic                                  gnt_i,
    input  logic                                  rvalid_i,
    input  logic [pet_mem_pkg::DATA_WIDTH-1:0]     rdata_i
);
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_GNT,
        ST_WAIT_DATA,
        ST_DONE
    } state_t;

    state_t state_q;
    logic   access;

    assign access = psel_i && penable_i;

    // Request only in the access phase, and drop it once granted
    assign req_o       = access && (state_q == ST_IDLE || state_q == ST_WAIT_GNT);
    assign req_write_o = pwrite_i;
    assign req_addr_o  = paddr_i;        // Held stable by the APB master
    assign req_wdata_o = pwdata_i;

    assign pready_o = (state_q == ST_DONE);

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE, ST_WAIT_GNT: begin
                    if (req_o && gnt_i) begin
                        state_q <= pwrite_i ? ST_DONE : ST_WAIT_DATA;
                    end else if (req_o) begin
                        state_q <= ST_WAIT_GNT;   // Lost arbitration, keep asking
                    end
                end
                ST_WAIT_DATA: begin
                    if (rvalid_i) state_q <= ST_DONE;
                end
                default: state_q <= ST_IDLE;    // Done lasts one cycle
            endcase
        end
    end

    // Read byte is held until the next read completes
    always_ff @(posedge clock_i) begin
        if (state_q == ST_WAIT_DATA && rvalid_i) begin
            prdata_o <= rdata_i;
        end
    end

endmodule

//--- hw/video_fetch.sv
// Raster fetcher reading the character screen one byte at a time
// Addresses run from VIDEO_BASE and wrap after VIDEO_BYTES, reads only

`timescale 1ns/1ps

module video_fetch (
    input  logic                                  clock_i,
    input  logic                                  reset_i,

    // Request to the arbiter, always a read
    output logic                                  req_o,
    output logic [pet_mem_pkg::RAM_ADDR_WIDTH-1:0] req_addr_o,
    input  logic                                  gnt_i,
    input  logic                                  rvalid_i,
    input  logic [pet_mem_pkg::DATA_WIDTH-1:0]     rdata_i,

    // Fetched screen byte
    output logic [pet_mem_pkg::DATA_WIDTH-1:0]     video_data_o,
    output logic                                  video_valid_o
);
    import pet_mem_pkg::*;

    typedef enum logic [1:0] {
        V_GAP,
        V_REQ,
        V_WAIT
    } vstate_t;

    vstate_t                       state_q;
    logic [VIDEO_OFFSET_WIDTH-1:0] offset_q;
    logic [VIDEO_GAP_WIDTH-1:0]    gap_q;

    assign req_o      = (state_q == V_REQ);
    assign req_addr_o = VIDEO_BASE + RAM_ADDR_WIDTH'(offset_q);

    // Reset starts in the gap, so the first fetch is offset 0 after VIDEO_GAP cycles
    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            state_q       <= V_GAP;
            offset_q      <= '0;
            gap_q         <= '0;
            video_valid_o <= 1'b0;
        end else begin
            video_valid_o <= 1'b0;
            case (state_q)
                V_GAP: begin
                    if (gap_q == VIDEO_GAP_WIDTH'(VIDEO_GAP - 1)) begin
                        state_q <= V_REQ;
                    end else begin
                        gap_q <= gap_q + 1'b1;
                    end
                end
                V_REQ: begin
                    if (gnt_i) state_q <= V_WAIT;   // Request held until granted
                end
                default: begin
                    if (rvalid_i) begin
                        video_valid_o <= 1'b1;
                        state_q       <= V_GAP;
                        gap_q         <= '0;
                        // Step to the next screen byte, wrapping at the end of the frame
                        if (offset_q == VIDEO_OFFSET_WIDTH'(VIDEO_BYTES - 1)) begin
                            offset_q <= '0;
                        end else begin
                            offset_q <= offset_q + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clock_i) begin
        if (state_q == V_WAIT && rvalid_i) begin
            video_data_o <= rdata_i;
        end
    end

endmodule

//--- hw/mem_arbiter.sv
// Single-port SRAM arbiter, video at fixed priority, CPU and host round-robin
// Requests must be held until granted and dropped the cycle after
// Read data returns one cycle after the grant on shared lines

`timescale 1ns/1ps

module mem_arbiter (
    input  logic                                      clock_i,
    input  logic                                      reset_i,

    // Requesters, indexed by REQ_VIDEO, REQ_CPU and REQ_HOST
    input  logic [pet_mem_pkg::NUM_REQ-1:0]            req_i,
    input  logic [pet_mem_pkg::REQ_HOST:pet_mem_pkg::REQ_CPU] write_i,
    input  logic [pet_mem_pkg::NUM_REQ-1:0][pet_mem_pkg::RAM_ADDR_WIDTH-1:0] addr_i,
    input  logic [pet_mem_pkg::REQ_HOST:pet_mem_pkg::REQ_CPU]
                 [pet_mem_pkg::DATA_WIDTH-1:0]         wdata_i,
    output logic [pet_mem_pkg::NUM_REQ-1:0]            gnt_o,
    output logic [pet_mem_pkg::NUM_REQ-1:0]            rvalid_o,
    output logic [pet_mem_pkg::DATA_WIDTH-1:0]         rdata_o,

    // SRAM pins
    output logic [pet_mem_pkg::RAM_ADDR_WIDTH-1:0]     ram_addr_o,
    output logic [pet_mem_pkg::DATA_WIDTH-1:0]         ram_data_o,
    input  logic [pet_mem_pkg::DATA_WIDTH-1:0]         ram_data_i,
    output logic                                      ram_we_n_o,
    output logic                                      ram_oe_n_o
);
    import pet_mem_pkg::*;

    logic [NUM_REQ-1:0] prev_gnt_q;     // Granted last cycle
    logic [NUM_REQ-1:0] rd_gnt_q;       // Read whose data returns this cycle
    logic               last_host_q;    // Host took the last APB grant
    logic [NUM_REQ-1:0] eligible;
    logic               gnt_write;
    logic               gnt_read;

    // ******************************************************************
    // Winner selection
    // ******************************************************************

    // A request still held from last cycle's grant must not win again
    assign eligible = req_i & ~prev_gnt_q;

    always_comb begin
        gnt_o = '0;
        if (eligible[REQ_VIDEO]) begin
            gnt_o[REQ_VIDEO] = 1'b1;
        end else if (eligible[REQ_CPU] && eligible[REQ_HOST]) begin
            // Tie goes to the APB port that did not win last
            if (last_host_q) begin
                gnt_o[REQ_CPU] = 1'b1;
            end else begin
                gnt_o[REQ_HOST] = 1'b1;
            end
        end else if (eligible[REQ_CPU]) begin
            gnt_o[REQ_CPU] = 1'b1;
        end else if (eligible[REQ_HOST]) begin
            gnt_o[REQ_HOST] = 1'b1;
        end
    end

    // ******************************************************************
    // SRAM pins, valid in the grant cycle
    // ******************************************************************
    always_comb begin
        ram_addr_o = '0;
        ram_data_o = '0;
        gnt_write  = 1'b0;
        if (gnt_o[REQ_VIDEO]) begin
            ram_addr_o = addr_i[REQ_VIDEO];     // Video only reads
        end else if (gnt_o[REQ_CPU]) begin
            ram_addr_o = addr_i[REQ_CPU];
            ram_data_o = wdata_i[REQ_CPU];
            gnt_write  = write_i[REQ_CPU];
        end else if (gnt_o[REQ_HOST]) begin
            ram_addr_o = addr_i[REQ_HOST];
            ram_data_o = wdata_i[REQ_HOST];
            gnt_write  = write_i[REQ_HOST];
        end
    end

    assign gnt_read   = (|gnt_o) && !gnt_write;
    assign ram_we_n_o = !gnt_write;
    assign ram_oe_n_o = !gnt_read;

    // ******************************************************************
    // Grant history and read return
    // ******************************************************************
    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            prev_gnt_q  <= '0;
            rd_gnt_q    <= '0;
            last_host_q <= 1'b0;
        end else begin
            prev_gnt_q <= gnt_o;
            rd_gnt_q   <= gnt_read ? gnt_o : '0;
            if (gnt_o[REQ_CPU]) begin
                last_host_q <= 1'b0;
            end else if (gnt_o[REQ_HOST]) begin
                last_host_q <= 1'b1;
            end
        end
    end

    // SRAM registers its output, so the data lines up with rd_gnt_q
    assign rvalid_o = rd_gnt_q;
    assign rdata_o  = ram_data_i;

endmodule

//--- hw/pet_mem_top.sv
// Shared PET memory, two APB ports and the video fetcher on one external SRAM
// SRAM must return read data one clock after the output enable cycle

`timescale 1ns/1ps

module pet_mem_top (
    input  logic                                  clock_i,
    input  logic                                  reset_i,

    // CPU bus APB port
    input  logic                                  cpu_psel_i,
    input  logic                                  cpu_penable_i,
    input  logic                                  cpu_pwrite_i,
    input  logic [pet_mem_pkg::RAM_ADDR_WIDTH-1:0] cpu_paddr_i,
    input  logic [pet_mem_pkg::DATA_WIDTH-1:0]     cpu_pwdata_i,
    output logic [pet_mem_pkg::DATA_WIDTH-1:0]     cpu_prdata_o,
    output logic                                  cpu_pready_o,

    // Host bridge APB port
    input  logic                                  host_psel_i,
    input  logic                                  host_penable_i,
    input  logic                                  host_pwrite_i,
    input  logic [pet_mem_pkg::RAM_ADDR_WIDTH-1:0] host_paddr_i,
    input  logic [pet_mem_pkg::DATA_WIDTH-1:0]     host_pwdata_i,
    output logic [pet_mem_pkg::DATA_WIDTH-1:0]     host_prdata_o,
    output logic                                  host_pready_o,

    // Video byte stream
    output logic [pet_mem_pkg::DATA_WIDTH-1:0]     video_data_o,
    output logic                                  video_valid_o,

    // External SRAM
    output logic [pet_mem_pkg::RAM_ADDR_WIDTH-1:0] ram_addr_o,
    output logic [pet_mem_pkg::DATA_WIDTH-1:0]     ram_data_o,
    input  logic [pet_mem_pkg::DATA_WIDTH-1:0]     ram_data_i,
    output logic                                  ram_we_n_o,
    output logic                                  ram_oe_n_o
);
    import pet_mem_pkg::*;

    logic [NUM_REQ-1:0]                     req;
    logic [REQ_HOST:REQ_CPU]                req_write;
    logic [NUM_REQ-1:0][RAM_ADDR_WIDTH-1:0] req_addr;
    logic [REQ_HOST:REQ_CPU][DATA_WIDTH-1:0] req_wdata;
    logic [NUM_REQ-1:0]                     gnt;
    logic [NUM_REQ-1:0]                     rvalid;
    logic [DATA_WIDTH-1:0]                  rdata;

    apb_mem_port u_cpu_port (
        .clock_i    (clock_i),
        .reset_i    (reset_i),
        .psel_i     (cpu_psel_i),
        .penable_i  (cpu_penable_i),
        .pwrite_i   (cpu_pwrite_i),
        .paddr_i    (cpu_paddr_i),
        .pwdata_i   (cpu_pwdata_i),
        .prdata_o   (cpu_prdata_o),
        .pready_o   (cpu_pready_o),
        .req_o      (req[REQ_CPU]),
        .req_write_o(req_write[REQ_CPU]),
        .req_addr_o (req_addr[REQ_CPU]),
        .req_wdata_o(req_wdata[REQ_CPU]),
        .gnt_i      (gnt[REQ_CPU]),
        .rvalid_i   (rvalid[REQ_CPU]),
        .rdata_i    (rdata)
    );

    apb_mem_port u_host_port (
        .clock_i    (clock_i),
        .reset_i    (reset_i),
        .psel_i     (host_psel_i),
        .penable_i  (host_penable_i),
        .pwrite_i   (host_pwrite_i),
        .paddr_i    (host_paddr_i),
        .pwdata_i   (host_pwdata_i),
        .prdata_o   (host_prdata_o),
        .pready_o   (host_pready_o),
        .req_o      (req[REQ_HOST]),
        .req_write_o(req_write[REQ_HOST]),
        .req_addr_o (req_addr[REQ_HOST]),
        .req_wdata_o(req_wdata[REQ_HOST]),
        .gnt_i      (gnt[REQ_HOST]),
        .rvalid_i   (rvalid[REQ_HOST]),
        .rdata_i    (rdata)
    );

    video_fetch u_video (
        .clock_i      (clock_i),
        .reset_i      (reset_i),
        .req_o        (req[REQ_VIDEO]),
        .req_addr_o   (req_addr[REQ_VIDEO]),
        .gnt_i        (gnt[REQ_VIDEO]),
        .rvalid_i     (rvalid[REQ_VIDEO]),
        .rdata_i      (rdata),
        .video_data_o (video_data_o),
        .video_valid_o(video_valid_o)
    );

    mem_arbiter u_arbiter (
        .clock_i   (clock_i),
        .reset_i   (reset_i),
        .req_i     (req),
        .write_i   (req_write),
        .addr_i    (req_addr),
        .wdata_i   (req_wdata),
        .gnt_o     (gnt),
        .rvalid_o  (rvalid),
        .rdata_o   (rdata),
        .ram_addr_o(ram_addr_o),
        .ram_data_o(ram_data_o),
        .ram_data_i(ram_data_i),
        .ram_we_n_o(ram_we_n_o),
        .ram_oe_n_o(ram_oe_n_o)
    );

endmodule

//--- verification/sram_model.sv
// Behavioral SRAM for simulation, one access per clock
// Writes on the clock edge while we_n is low, registers read data while oe_n is low

`timescale 1ns/1ps

module sram_model (
    input  logic                                  clock_i,
    input  logic [pet_mem_pkg::RAM_ADDR_WIDTH-1:0] addr_i,
    input  logic [pet_mem_pkg::DATA_WIDTH-1:0]     data_i,
    output logic [pet_mem_pkg::DATA_WIDTH-1:0]     data_o,
    input  logic                                  we_n_i,
    input  logic                                  oe_n_i
);
    import pet_mem_pkg::*;

    logic [DATA_WIDTH-1:0] mem [0:2**RAM_ADDR_WIDTH-1];

    always @(posedge clock_i) begin
        if (!we_n_i) mem[addr_i] <= data_i;
        if (!oe_n_i) data_o <= mem[addr_i];     // Data shows up one clock later
    end

    // Screen bytes get their low address byte, the rest mix in the upper address bits
    task automatic fill(input int base, input int len);
        for (int a = 0; a < 2**RAM_ADDR_WIDTH; a++) begin
            if (a >= base && a < base + len) begin
                mem[a] = 8'(a);
            end else begin
                mem[a] = 8'(a) ^ 8'(a >> 8);
            end
        end
    endtask

endmodule

//--- verification/pet_mem_chk.sv
// Concurrent checks on grants, read return and SRAM enables of the arbiter
// Bound into every mem_arbiter instance

`timescale 1ns/1ps

module pet_mem_chk (
    input logic                           clock_i,
    input logic                           reset_i,
    input logic [pet_mem_pkg::NUM_REQ-1:0] req_i,
    input logic [pet_mem_pkg::REQ_HOST:pet_mem_pkg::REQ_CPU] write_i,
    input logic [pet_mem_pkg::NUM_REQ-1:0] gnt_i,
    input logic [pet_mem_pkg::NUM_REQ-1:0] rvalid_i,
    input logic                           ram_we_n_i,
    input logic                           ram_oe_n_i
);
    import pet_mem_pkg::*;

    int unsigned        fail_count = 0;    // Read by the testbench monitor
    logic [NUM_REQ-1:0] wr_gnt;            // Grant to an APB write
    logic [NUM_REQ-1:0] rd_gnt;            // Grant to video or an APB read

    task automatic count_failure(input string what);
        fail_count++;
        $error("%s", what);
    endtask

    // Access type taken from the requesters' own write flags
    always_comb begin
        wr_gnt = '0;
        for (int r = REQ_CPU; r <= REQ_HOST; r++) begin
            wr_gnt[r] = gnt_i[r] && write_i[r];
        end
    end

    assign rd_gnt = gnt_i & ~wr_gnt;

    assert property (@(posedge clock_i) disable iff (reset_i) $onehot0(gnt_i))
        else count_failure("more than one grant in a cycle");

    // Write and read enables are exclusive and follow the granted access
    assert property (@(posedge clock_i) disable iff (reset_i)
                     (ram_we_n_i || ram_oe_n_i)
                     && (ram_we_n_i == !(|wr_gnt))
                     && (ram_oe_n_i == !(|rd_gnt)))
        else count_failure("SRAM enables do not match the granted access");

    assert property (@(posedge clock_i) disable iff (reset_i) (gnt_i & ~req_i) == '0)
        else count_failure("grant without a request");

    // Read-valid exactly one cycle after a read grant, and never otherwise
    assert property (@(posedge clock_i) disable iff (reset_i)
                     rvalid_i == $past(rd_gnt))
        else count_failure("read-valid does not follow the read grant");

    assert property (@(posedge clock_i) disable iff (reset_i)
                     req_i[REQ_VIDEO] |-> gnt_i[REQ_VIDEO])
        else count_failure("video request not granted at once");

endmodule

bind mem_arbiter pet_mem_chk u_chk (
    .clock_i   (clock_i),
    .reset_i   (reset_i),
    .req_i     (req_i),
    .write_i   (write_i),
    .gnt_i     (gnt_o),
    .rvalid_i  (rvalid_o),
    .ram_we_n_i(ram_we_n_o),
    .ram_oe_n_i(ram_oe_n_o)
);

//--- verification/pet_mem_tb.sv
// Drives both APB ports with random transfers and checks reads and video bytes
// against a reference memory that mirrors the SRAM fill and every APB write

`timescale 1ns/1ps

module pet_mem_tb;
    import pet_mem_pkg::*;

    localparam int CLK_PERIOD     = 4;
    localparam int NUM_XFERS      = 100;
    localparam int FRAME_CYCLES   = VIDEO_BYTES * (VIDEO_GAP + 2);   // Gap, grant, data
    localparam int TIMEOUT_CYCLES = NUM_XFERS * 20 + FRAME_CYCLES;

    logic                      clock_i = 1'b0;
    logic                      reset_i;
    logic                      cpu_psel, cpu_penable, cpu_pwrite, cpu_pready;
    logic                      host_psel, host_penable, host_pwrite, host_pready;
    logic [RAM_ADDR_WIDTH-1:0] cpu_paddr, host_paddr, ram_addr;
    logic [DATA_WIDTH-1:0]     cpu_pwdata, cpu_prdata, host_pwdata, host_prdata;
    logic [DATA_WIDTH-1:0]     video_data, ram_wdata, ram_rdata;
    logic                      video_valid, ram_we_n, ram_oe_n;

    logic [DATA_WIDTH-1:0]     ref_mem [0:2**RAM_ADDR_WIDTH-1];
    logic [RAM_ADDR_WIDTH-1:0] cpu_addr [16];
    logic [RAM_ADDR_WIDTH-1:0] host_addr [16];
    logic [DATA_WIDTH-1:0]     cpu_data [16];
    logic [DATA_WIDTH-1:0]     host_data [16];
    int                        seed = 31284;
    int                        fetch_count = 0;

    always #(CLK_PERIOD / 2) clock_i = ~clock_i;

    pet_mem_top u_pet_mem_top (
        .clock_i       (clock_i),
        .reset_i       (reset_i),
        .cpu_psel_i    (cpu_psel),
        .cpu_penable_i (cpu_penable),
        .cpu_pwrite_i  (cpu_pwrite),
        .cpu_paddr_i   (cpu_paddr),
        .cpu_pwdata_i  (cpu_pwdata),
        .cpu_prdata_o  (cpu_prdata),
        .cpu_pready_o  (cpu_pready),
        .host_psel_i   (host_psel),
        .host_penable_i(host_penable),
        .host_pwrite_i (host_pwrite),
        .host_paddr_i  (host_paddr),
        .host_pwdata_i (host_pwdata),
        .host_prdata_o (host_prdata),
        .host_pready_o (host_pready),
        .video_data_o  (video_data),
        .video_valid_o (video_valid),
        .ram_addr_o    (ram_addr),
        .ram_data_o    (ram_wdata),
        .ram_data_i    (ram_rdata),
        .ram_we_n_o    (ram_we_n),
        .ram_oe_n_o    (ram_oe_n)
    );

    sram_model u_sram (
        .clock_i(clock_i),
        .addr_i (ram_addr),
        .data_i (ram_wdata),
        .data_o (ram_rdata),
        .we_n_i (ram_we_n),
        .oe_n_i (ram_oe_n)
    );

    // ******************************************************************
    // Failure reporting
    // ******************************************************************
    task automatic stop_run();
        $display("Test failures found");
        $fatal(1, "Stopped at the first failure");
    endtask

    task automatic report_mismatch(input string name, input logic [7:0] exp,
                                   input logic [7:0] got);
        $display("FAIL at %0t ns: %s expected 0x%02h got 0x%02h", $time, name, exp, got);
        stop_run();
    endtask

    // ******************************************************************
    // APB masters, one transfer per call with an idle cycle after it
    // ******************************************************************
    task automatic cpu_xfer(input logic wr, input logic [RAM_ADDR_WIDTH-1:0] addr,
                            input logic [DATA_WIDTH-1:0] wdata);
        @(posedge clock_i);
        cpu_psel   <= 1'b1;                 // Setup cycle
        cpu_pwrite <= wr;
        cpu_paddr  <= addr;
        cpu_pwdata <= wdata;
        @(posedge clock_i);
        cpu_penable <= 1'b1;
        @(negedge clock_i);
        while (!cpu_pready) @(negedge clock_i);
        if (!wr) begin
            assert (cpu_prdata == ref_mem[addr])
                else report_mismatch("cpu_prdata_o", ref_mem[addr], cpu_prdata);
        end
        @(posedge clock_i);
        cpu_psel    <= 1'b0;
        cpu_penable <= 1'b0;
        if (wr) ref_mem[addr] = wdata;      // SRAM already holds it
    endtask

    task automatic host_xfer(input logic wr, input logic [RAM_ADDR_WIDTH-1:0] addr,
                             input logic [DATA_WIDTH-1:0] wdata);
        @(posedge clock_i);
        host_psel   <= 1'b1;
        host_pwrite <= wr;
        host_paddr  <= addr;
        host_pwdata <= wdata;
        @(posedge clock_i);
        host_penable <= 1'b1;
        @(negedge clock_i);
        while (!host_pready) @(negedge clock_i);
        if (!wr) begin
            assert (host_prdata == ref_mem[addr])
                else report_mismatch("host_prdata_o", ref_mem[addr], host_prdata);
        end
        @(posedge clock_i);
        host_psel    <= 1'b0;
        host_penable <= 1'b0;
        if (wr) ref_mem[addr] = wdata;
    endtask

    // Every video byte matches the screen offset it was fetched from
    always @(negedge clock_i) begin
        if (video_valid === 1'b1) begin
            assert (video_data == ref_mem[int'(VIDEO_BASE) + fetch_count % VIDEO_BYTES])
                else report_mismatch("video_data_o",
                                     ref_mem[int'(VIDEO_BASE) + fetch_count % VIDEO_BYTES],
                                     video_data);
            fetch_count++;
        end
    end

    always @(negedge clock_i) begin
        if (u_pet_mem_top.u_arbiter.u_chk.fail_count != 0) begin
            $display("An arbiter assertion failed, seen at %0t ns", $time);
            stop_run();
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        stop_run();
    end

    // ******************************************************************
    // Test sequence
    // ******************************************************************
    initial begin
        int offs;
        int target;
        reset_i      = 1'b1;
        cpu_psel     = 1'b0;
        cpu_penable  = 1'b0;
        cpu_pwrite   = 1'b0;
        cpu_paddr    = '0;
        cpu_pwdata   = '0;
        host_psel    = 1'b0;
        host_penable = 1'b0;
        host_pwrite  = 1'b0;
        host_paddr   = '0;
        host_pwdata  = '0;

        // Screen bytes hold their low address byte, so video data is known up front
        for (int a = 0; a < 2**RAM_ADDR_WIDTH; a++) begin
            if (a >= VIDEO_BASE && a < VIDEO_BASE + VIDEO_BYTES) begin
                ref_mem[a] = 8'(a);
            end else begin
                ref_mem[a] = 8'(a) ^ 8'(a >> 8);
            end
        end
        u_sram.fill(VIDEO_BASE, VIDEO_BYTES);

        // CPU above 0x4000, host in 0x1000 to 0x3fff, both clear of the screen
        for (int i = 0; i < 16; i++) begin
            cpu_addr[i]  = 15'h4000 | 15'($random(seed));
            host_addr[i] = 15'h1000 | (15'($random(seed)) & 15'h2fff);
            cpu_data[i]  = 8'($random(seed));
            host_data[i] = 8'($random(seed));
        end

        for (int i = 0; i < 4; i++) begin
            @(posedge clock_i);
            if (i == 3) reset_i <= 1'b0;
            @(negedge clock_i);
            assert (!cpu_pready) else report_mismatch("cpu_pready_o", 0, cpu_pready);
            assert (!host_pready) else report_mismatch("host_pready_o", 0, host_pready);
            assert (!video_valid) else report_mismatch("video_valid_o", 0, video_valid);
            assert (ram_we_n) else report_mismatch("ram_we_n_o", 1, ram_we_n);
            assert (ram_oe_n) else report_mismatch("ram_oe_n_o", 1, ram_oe_n);
        end

        // CPU round trip
        for (int i = 0; i < 16; i++) cpu_xfer(1'b1, cpu_addr[i], cpu_data[i]);
        for (int i = 0; i < 16; i++) cpu_xfer(1'b0, cpu_addr[i], '0);

        // Both ports at once, interleaved with video fetches
        fork
            for (int i = 0; i < 16; i++) begin
                cpu_xfer(1'b1, cpu_addr[i], ~cpu_data[i]);
                cpu_xfer(1'b0, cpu_addr[i], '0);
            end
            for (int j = 0; j < 16; j++) begin
                host_xfer(1'b1, host_addr[j], host_data[j]);
                host_xfer(1'b0, host_addr[j], '0);
            end
        join

        // Host rewrites screen bytes, then a full idle frame must show them
        for (int i = 0; i < 4; i++) begin
            offs = int'(VIDEO_BASE) + ($unsigned($random(seed)) % VIDEO_BYTES);
            host_xfer(1'b1, 15'(offs), ~ref_mem[offs]);
        end
        target = fetch_count + VIDEO_BYTES + 1;
        wait (fetch_count >= target);

        if (u_pet_mem_top.u_arbiter.u_chk.fail_count == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("An arbiter assertion failed during the run");
            stop_run();
        end
    end

endmodule

//--- pet_mem.f
hw/pet_mem_pkg.sv
hw/apb_mem_port.sv
hw/video_fetch.sv
hw/mem_arbiter.sv
hw/pet_mem_top.sv
verification/sram_model.sv
verification/pet_mem_chk.sv
verification/pet_mem_tb.sv

//--- Bender.yml
package:
  name: pet_mem

sources:
  - files:
      - hw/pet_mem_pkg.sv
      - hw/apb_mem_port.sv
      - hw/video_fetch.sv
      - hw/mem_arbiter.sv
      - hw/pet_mem_top.sv
  - target: test
    files:
      - verification/sram_model.sv
      - verification/pet_mem_chk.sv
      - verification/pet_mem_tb.sv
